//--- hcsr_defs.svh
//////////////////////////////////////////////////////////////////////
// Shared constants for the hypervisor CSR block, RV64 only
// Addresses follow the H extension map; RV32 high halves do not exist
// UXL reads as a fixed value and UBE reads zero (little-endian only)
//////////////////////////////////////////////////////////////////////

`ifndef HCSR_DEFS_SVH
`define HCSR_DEFS_SVH

// Register width
`define XLEN 64

//////////////////////////////////////////////////////////////////////
// CSR addresses
//////////////////////////////////////////////////////////////////////

// HS level
`define ADR_HSTATUS   12'h600
`define ADR_HEDELEG   12'h602
`define ADR_HIDELEG   12'h603
`define ADR_HTVAL     12'h643
`define ADR_HIP       12'h644
`define ADR_HVIP      12'h645
`define ADR_HTINST    12'h64A

// Guest supervisor
`define ADR_VSSTATUS  12'h200
`define ADR_VSTVEC    12'h205
`define ADR_VSSCRATCH 12'h240
`define ADR_VSEPC     12'h241
`define ADR_VSCAUSE   12'h242
`define ADR_VSTVAL    12'h243

//////////////////////////////////////////////////////////////////////
// Masks and field positions
//////////////////////////////////////////////////////////////////////

// Only synchronous exception codes 0..15 can be delegated
`define HEDELEG_MASK 64'h0000_0000_0000_FFFF
`define HIDELEG_MASK 12'hFFF

// Previous virtualization mode in HSTATUS
`define HSTATUS_SPV_BIT 7

// U-mode XLEN encoding for 64 bits
`define UXL_VALUE 2'd2

`endif

//--- hcsr_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types shared by the hypervisor CSR block
// Every view of a CSR word is exactly XLEN bits wide
// VS status keeps only the writable fields; the rest is rebuilt on read
//////////////////////////////////////////////////////////////////////

`include "hcsr_defs.svh"

package hcsrPkg;

  typedef logic [`XLEN-1:0] xlenWord_t;
  typedef logic [11:0]      csrAdr_t;
  typedef logic [11:0]      irqBits_t;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_S = 2'd1,
    PRIV_M = 2'd3
  } privMode_t;

  // One name per kept register
  typedef enum logic [3:0] {
    REG_NONE, REG_HSTATUS, REG_HEDELEG, REG_HIDELEG, REG_HIP, REG_HVIP,
    REG_HTVAL, REG_HTINST, REG_VSSTATUS, REG_VSTVEC, REG_VSSCRATCH,
    REG_VSEPC, REG_VSCAUSE, REG_VSTVAL
  } hcsrReg_t;

  // VSSTATUS bit layout, MSB first
  typedef struct packed {
    logic        sd;
    logic [28:0] zero62;
    logic [1:0]  uxl;
    logic [11:0] zero31;
    logic        mxr;
    logic        sum;
    logic        zero17;
    logic [1:0]  xs;
    logic [1:0]  fs;
    logic [3:0]  zero12;
    logic        spp;
    logic        zero7;
    logic        ube;
    logic        spie;
    logic [2:0]  zero4;
    logic        sie;
    logic        zero0;
  } statusView_t;

  typedef struct packed {
    logic [61:0] base;
    logic [1:0]  mode;
  } tvecView_t;

  // A written CSR value seen raw, as a status word or as a trap vector
  typedef union packed {
    xlenWord_t   raw;
    statusView_t status;
    tvecView_t   tvec;
  } csrWord_t;

  typedef struct packed {
    xlenWord_t hstatus;
    xlenWord_t hedeleg;
    irqBits_t  hideleg;
    irqBits_t  hvip;
    xlenWord_t htval;
    xlenWord_t htinst;
  } hsState_t;

  typedef struct packed {
    logic       mxr;
    logic       sum;
    logic [1:0] fs;
    logic       spp;
    logic       spie;
    logic       sie;
    xlenWord_t  tvec;
    xlenWord_t  scratch;
    xlenWord_t  epc;
    xlenWord_t  cause;
    xlenWord_t  tval;
  } vsState_t;

endpackage

//--- hcsr_if.sv
//////////////////////////////////////////////////////////////////////
// Internal buses of the hypervisor CSR block
// The write bus carries one decoded write per cycle and the bank state
// The trap bus is read-only for the banks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface hcsrWriteIf import hcsrPkg::*; ();

  logic     writeEn;
  hcsrReg_t regSel;
  csrWord_t writeValue;
  hsState_t hsState;
  vsState_t vsState;

  modport ctrl (
    output writeEn, regSel, writeValue,
    input  hsState, vsState
  );

  // Each bank drives only its own state field
  modport bank (
    input  writeEn, regSel, writeValue,
    output hsState, vsState
  );

endinterface

interface hcsrTrapIf import hcsrPkg::*; ();

  logic       hsTrap;
  logic       vsTrap;
  logic       hsReturn;
  logic       vsReturn;
  privMode_t  privMode;
  logic       virtMode;
  xlenWord_t  nextEpc;
  logic [4:0] nextCause;
  xlenWord_t  nextTval;
  xlenWord_t  nextHtval;
  xlenWord_t  nextHtinst;

  modport src (
    output hsTrap, vsTrap, hsReturn, vsReturn, privMode, virtMode,
    output nextEpc, nextCause, nextTval, nextHtval, nextHtinst
  );

  modport bank (
    input hsTrap, vsTrap, hsReturn, vsReturn, privMode, virtMode,
    input nextEpc, nextCause, nextTval, nextHtval, nextHtinst
  );

endinterface

//--- hcsrAccessCtrl.sv
//////////////////////////////////////////////////////////////////////
// CSR access decode for the hypervisor block, purely combinational
// Read data and illegal flag are valid in the cycle of the access
// Illegal reads return zero; illegal writes never reach a bank
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcsr_defs.svh"

module hcsrAccessCtrl import hcsrPkg::*; (
  input  logic             csrWrite,
  input  csrAdr_t          csrAdr,
  input  xlenWord_t        csrWriteVal,
  input  privMode_t        privMode,
  input  logic             virtMode,
  input  irqBits_t         mipBits,
  hcsrWriteIf.ctrl         wr,
  output xlenWord_t        csrReadVal,
  output logic             illegalAccess
);

  hcsrReg_t    regSel;
  logic        isHReg;
  logic        isVsReg;
  logic        legalH;
  logic        legalVs;
  logic        writeOk;
  xlenWord_t   readData;
  statusView_t statusView;

  //////////////////////////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    regSel  = REG_NONE;
    isHReg  = 1'b0;
    isVsReg = 1'b0;
    case (csrAdr)
      `ADR_HSTATUS:   begin regSel = REG_HSTATUS;   isHReg = 1'b1; end
      `ADR_HEDELEG:   begin regSel = REG_HEDELEG;   isHReg = 1'b1; end
      `ADR_HIDELEG:   begin regSel = REG_HIDELEG;   isHReg = 1'b1; end
      `ADR_HIP:       begin regSel = REG_HIP;       isHReg = 1'b1; end
      `ADR_HVIP:      begin regSel = REG_HVIP;      isHReg = 1'b1; end
      `ADR_HTVAL:     begin regSel = REG_HTVAL;     isHReg = 1'b1; end
      `ADR_HTINST:    begin regSel = REG_HTINST;    isHReg = 1'b1; end
      `ADR_VSSTATUS:  begin regSel = REG_VSSTATUS;  isVsReg = 1'b1; end
      `ADR_VSTVEC:    begin regSel = REG_VSTVEC;    isVsReg = 1'b1; end
      `ADR_VSSCRATCH: begin regSel = REG_VSSCRATCH; isVsReg = 1'b1; end
      `ADR_VSEPC:     begin regSel = REG_VSEPC;     isVsReg = 1'b1; end
      `ADR_VSCAUSE:   begin regSel = REG_VSCAUSE;   isVsReg = 1'b1; end
      `ADR_VSTVAL:    begin regSel = REG_VSTVAL;    isVsReg = 1'b1; end
      default:        regSel = REG_NONE;
    endcase
  end

  // H registers are closed to a guest, VS registers only to U/VU
  assign legalH  = (privMode == PRIV_M) | ((privMode == PRIV_S) & ~virtMode);
  assign legalVs = (privMode == PRIV_M) | (privMode == PRIV_S);

  // HIP is derived, so it is never a write target
  assign writeOk = csrWrite & ((isHReg & legalH & (regSel != REG_HIP)) |
                               (isVsReg & legalVs));

  assign wr.writeEn        = writeOk;
  assign wr.regSel         = regSel;
  assign wr.writeValue.raw = csrWriteVal;

  //////////////////////////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////////////////////////

  // Rebuild the guest status word from the stored fields
  always_comb begin
    statusView      = '0;
    statusView.uxl  = `UXL_VALUE;
    statusView.mxr  = wr.vsState.mxr;
    statusView.sum  = wr.vsState.sum;
    statusView.fs   = wr.vsState.fs;
    statusView.spp  = wr.vsState.spp;
    statusView.spie = wr.vsState.spie;
    statusView.sie  = wr.vsState.sie;
    // No extension state, so only a dirty FPU sets SD
    statusView.sd   = (wr.vsState.fs == 2'b11);
  end

  always_comb begin
    readData = '0;
    case (regSel)
      REG_HSTATUS:   readData = wr.hsState.hstatus;
      REG_HEDELEG:   readData = wr.hsState.hedeleg;
      REG_HIDELEG:   readData = {{(`XLEN-12){1'b0}}, wr.hsState.hideleg};
      REG_HIP:       readData = {{(`XLEN-12){1'b0}}, wr.hsState.hvip | mipBits};
      REG_HVIP:      readData = {{(`XLEN-12){1'b0}}, wr.hsState.hvip};
      REG_HTVAL:     readData = wr.hsState.htval;
      REG_HTINST:    readData = wr.hsState.htinst;
      REG_VSSTATUS:  readData = statusView;
      REG_VSTVEC:    readData = wr.vsState.tvec;
      REG_VSSCRATCH: readData = wr.vsState.scratch;
      REG_VSEPC:     readData = wr.vsState.epc;
      REG_VSCAUSE:   readData = wr.vsState.cause;
      REG_VSTVAL:    readData = wr.vsState.tval;
      default:       readData = '0;
    endcase
  end

  assign illegalAccess = (regSel == REG_NONE) | (isHReg & ~legalH) | (isVsReg & ~legalVs) |
                         (csrWrite & (regSel == REG_HIP));

  assign csrReadVal = illegalAccess ? '0 : readData;

endmodule

//--- hsRegBank.sv
//////////////////////////////////////////////////////////////////////
// HS-level trap and delegation registers
// Traps and sret win over a CSR write to the same register
// Only SPV in HSTATUS is touched by hardware
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcsr_defs.svh"

module hsRegBank import hcsrPkg::*; (
  input  logic     clk,
  input  logic     reset,
  hcsrWriteIf.bank wr,
  hcsrTrapIf.bank  trap
);

  hsState_t hsReg;
  logic     writeHstatus;
  logic     writeHedeleg;
  logic     writeHideleg;
  logic     writeHvip;
  logic     writeHtval;
  logic     writeHtinst;

  assign writeHstatus = wr.writeEn & (wr.regSel == REG_HSTATUS);
  assign writeHedeleg = wr.writeEn & (wr.regSel == REG_HEDELEG);
  assign writeHideleg = wr.writeEn & (wr.regSel == REG_HIDELEG);
  assign writeHvip    = wr.writeEn & (wr.regSel == REG_HVIP);
  assign writeHtval   = wr.writeEn & (wr.regSel == REG_HTVAL);
  assign writeHtinst  = wr.writeEn & (wr.regSel == REG_HTINST);

  always_ff @(posedge clk) begin
    if (reset) begin
      hsReg <= '0;
    end else begin
      // SPV remembers whether the trap came from a guest
      if (trap.hsTrap) begin
        hsReg.hstatus[`HSTATUS_SPV_BIT] <= trap.virtMode;
      end else if (trap.hsReturn) begin
        hsReg.hstatus[`HSTATUS_SPV_BIT] <= 1'b0;
      end else if (writeHstatus) begin
        hsReg.hstatus <= wr.writeValue.raw;
      end

      // Delegation, masked to the codes that may be delegated
      if (writeHedeleg) begin
        hsReg.hedeleg <= wr.writeValue.raw & `HEDELEG_MASK;
      end
      if (writeHideleg) begin
        hsReg.hideleg <= wr.writeValue.raw[11:0] & `HIDELEG_MASK;
      end

      if (writeHvip) begin
        hsReg.hvip <= wr.writeValue.raw[11:0];
      end

      // Trap values
      if (trap.hsTrap) begin
        hsReg.htval  <= trap.nextHtval;
        hsReg.htinst <= trap.nextHtinst;
      end else begin
        if (writeHtval) begin
          hsReg.htval <= wr.writeValue.raw;
        end
        if (writeHtinst) begin
          hsReg.htinst <= wr.writeValue.raw;
        end
      end
    end
  end

  assign wr.hsState = hsReg;

  // The core retires a trap or an sret in one cycle, never both
  assert property (@(posedge clk) disable iff (reset) !(trap.hsTrap && trap.hsReturn))
    else $error("hsTrap and hsReturn high in the same cycle");

endmodule

//--- vsRegBank.sv
//////////////////////////////////////////////////////////////////////
// Guest supervisor (VS) registers
// VSSTATUS holds only MXR, SUM, FS, SPP, SPIE and SIE
// A vsTrap or vsReturn takes priority over a CSR write in that cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcsr_defs.svh"

module vsRegBank import hcsrPkg::*; (
  input  logic     clk,
  input  logic     reset,
  hcsrWriteIf.bank wr,
  hcsrTrapIf.bank  trap
);

  vsState_t  vsReg;
  csrWord_t  wv;
  xlenWord_t trapCause;
  xlenWord_t tvecNext;
  logic      writeStatus;
  logic      writeTvec;
  logic      writeScratch;
  logic      writeEpc;
  logic      writeCause;
  logic      writeTval;

  assign wv = wr.writeValue;

  assign writeStatus  = wr.writeEn & (wr.regSel == REG_VSSTATUS);
  assign writeTvec    = wr.writeEn & (wr.regSel == REG_VSTVEC);
  assign writeScratch = wr.writeEn & (wr.regSel == REG_VSSCRATCH);
  assign writeEpc     = wr.writeEn & (wr.regSel == REG_VSEPC);
  assign writeCause   = wr.writeEn & (wr.regSel == REG_VSCAUSE);
  assign writeTval    = wr.writeEn & (wr.regSel == REG_VSTVAL);

  // Interrupt flag goes to the MSB, exception code to the low nibble
  assign trapCause = {trap.nextCause[4], {(`XLEN-5){1'b0}}, trap.nextCause[3:0]};

  // Only direct and vectored modes exist, so mode bit 1 reads zero
  assign tvecNext = {wv.tvec.base, 1'b0, wv.tvec.mode[0]};

  //////////////////////////////////////////////////////////////////////
  // Status
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      vsReg.mxr  <= 1'b0;
      vsReg.sum  <= 1'b0;
      vsReg.fs   <= 2'b00;
      vsReg.spp  <= 1'b0;
      vsReg.spie <= 1'b0;
      vsReg.sie  <= 1'b0;
    end else if (trap.vsTrap) begin
      vsReg.spie <= vsReg.sie;
      vsReg.sie  <= 1'b0;
      vsReg.spp  <= trap.privMode[0];
    end else if (trap.vsReturn) begin
      vsReg.sie  <= vsReg.spie;
      vsReg.spie <= 1'b1;
      vsReg.spp  <= 1'b0;
    end else if (writeStatus) begin
      vsReg.mxr  <= wv.status.mxr;
      vsReg.sum  <= wv.status.sum;
      vsReg.fs   <= wv.status.fs;
      vsReg.spp  <= wv.status.spp;
      vsReg.spie <= wv.status.spie;
      vsReg.sie  <= wv.status.sie;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Vector, scratch and trap records
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      vsReg.tvec    <= '0;
      vsReg.scratch <= '0;
      vsReg.epc     <= '0;
      vsReg.cause   <= '0;
      vsReg.tval    <= '0;
    end else begin
      if (writeTvec) begin
        vsReg.tvec <= tvecNext;
      end
      if (writeScratch) begin
        vsReg.scratch <= wv.raw;
      end
      if (trap.vsTrap) begin
        vsReg.epc   <= trap.nextEpc;
        vsReg.cause <= trapCause;
        vsReg.tval  <= trap.nextTval;
      end else begin
        if (writeEpc)   vsReg.epc   <= wv.raw;
        if (writeCause) vsReg.cause <= wv.raw;
        if (writeTval)  vsReg.tval  <= wv.raw;
      end
    end
  end

  assign wr.vsState = vsReg;

  // A guest trap and a guest sret cannot retire together
  assert property (@(posedge clk) disable iff (reset) !(trap.vsTrap && trap.vsReturn))
    else $error("vsTrap and vsReturn high in the same cycle");

endmodule

//--- hcsrTop.sv
//////////////////////////////////////////////////////////////////////
// Hypervisor CSR block for an RV64 core
// Reads are combinational; writes land at the next rising clk
// Traps and returns act at the edge where they are high
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcsr_defs.svh"

module hcsrTop import hcsrPkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       csrWrite,
  input  csrAdr_t    csrAdr,
  input  xlenWord_t  csrWriteVal,
  input  privMode_t  privMode,
  input  logic       virtMode,
  input  irqBits_t   mipBits,
  input  logic       hsTrap,
  input  logic       vsTrap,
  input  logic       hsReturn,
  input  logic       vsReturn,
  input  xlenWord_t  nextEpc,
  input  logic [4:0] nextCause,
  input  xlenWord_t  nextTval,
  input  xlenWord_t  nextHtval,
  input  xlenWord_t  nextHtinst,
  output xlenWord_t  csrReadVal,
  output logic       illegalAccess,
  output logic       hstatusSpv,
  output xlenWord_t  hedeleg,
  output irqBits_t   hideleg,
  output xlenWord_t  vstvec,
  output xlenWord_t  vsepc
);

  hcsrWriteIf writeBus ();
  hcsrTrapIf  trapBus ();

  // Trap side comes straight from the pipeline
  assign trapBus.hsTrap     = hsTrap;
  assign trapBus.vsTrap     = vsTrap;
  assign trapBus.hsReturn   = hsReturn;
  assign trapBus.vsReturn   = vsReturn;
  assign trapBus.privMode   = privMode;
  assign trapBus.virtMode   = virtMode;
  assign trapBus.nextEpc    = nextEpc;
  assign trapBus.nextCause  = nextCause;
  assign trapBus.nextTval   = nextTval;
  assign trapBus.nextHtval  = nextHtval;
  assign trapBus.nextHtinst = nextHtinst;

  hcsrAccessCtrl accessCtrl (
    .csrWrite      (csrWrite),
    .csrAdr        (csrAdr),
    .csrWriteVal   (csrWriteVal),
    .privMode      (privMode),
    .virtMode      (virtMode),
    .mipBits       (mipBits),
    .wr            (writeBus.ctrl),
    .csrReadVal    (csrReadVal),
    .illegalAccess (illegalAccess)
  );

  hsRegBank hsBank (.clk(clk), .reset(reset), .wr(writeBus.bank), .trap(trapBus.bank));

  vsRegBank vsBank (.clk(clk), .reset(reset), .wr(writeBus.bank), .trap(trapBus.bank));

  // State the rest of the core needs every cycle
  assign hstatusSpv = writeBus.hsState.hstatus[`HSTATUS_SPV_BIT];
  assign hedeleg    = writeBus.hsState.hedeleg;
  assign hideleg    = writeBus.hsState.hideleg;
  assign vstvec     = writeBus.vsState.tvec;
  assign vsepc      = writeBus.vsState.epc;

endmodule

//--- tbClockGen.sv
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset source
// 100 ns clock period, reset held high for the first 8 rising edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tbClockGen (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- tbHcsr.sv
//////////////////////////////////////////////////////////////////////
// Directed testbench for the hypervisor CSR block
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Stops at the first mismatch; a cycle limit guards against hangs
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "hcsr_defs.svh"

module tbHcsr import hcsrPkg::*; ();

  // Roughly ten times the length of all tests together
  localparam int CycleLimit = 2000;

  logic       clk;
  logic       reset;
  logic       csrWrite;
  csrAdr_t    csrAdr;
  xlenWord_t  csrWriteVal;
  privMode_t  privMode;
  logic       virtMode;
  irqBits_t   mipBits;
  logic       hsTrap;
  logic       vsTrap;
  logic       hsReturn;
  logic       vsReturn;
  xlenWord_t  nextEpc;
  xlenWord_t  nextTval;
  xlenWord_t  nextHtval;
  xlenWord_t  nextHtinst;
  logic [4:0] nextCause;
  xlenWord_t  csrReadVal;
  logic       illegalAccess;
  logic       hstatusSpv;
  xlenWord_t  hedeleg;
  irqBits_t   hideleg;
  xlenWord_t  vstvec;
  xlenWord_t  vsepc;

  logic [31:0] lfsrState = 32'hd560cd0f;
  int          cycleCount = 0;

  tbClockGen clockGen (.clk(clk), .reset(reset));

  hcsrTop uut (.*);

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic xlenWord_t randomBits(input int count);
    xlenWord_t value;
    logic      fb;
    value = '0;
    for (int i = 0; i < count; i++) begin
      fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      value     = {value[62:0], fb};
    end
    return value;
  endfunction

  task automatic abortRun();
    $display("Errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkWord(input string name, input xlenWord_t expected, input xlenWord_t actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkBit(input string name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
      abortRun();
    end
  endtask

  task automatic checkIrq(input string name, input irqBits_t expected, input irqBits_t actual);
    if (actual !== expected) begin
      $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      abortRun();
    end
  endtask

  // Index 0..12 names a kept register, anything else a random address
  function automatic csrAdr_t pickAddress(input logic [3:0] idx);
    case (idx)
      4'd0:    return `ADR_HSTATUS;
      4'd1:    return `ADR_HEDELEG;
      4'd2:    return `ADR_HIDELEG;
      4'd3:    return `ADR_HIP;
      4'd4:    return `ADR_HVIP;
      4'd5:    return `ADR_HTVAL;
      4'd6:    return `ADR_HTINST;
      4'd7:    return `ADR_VSSTATUS;
      4'd8:    return `ADR_VSTVEC;
      4'd9:    return `ADR_VSSCRATCH;
      4'd10:   return `ADR_VSEPC;
      4'd11:   return `ADR_VSCAUSE;
      4'd12:   return `ADR_VSTVAL;
      default: return csrAdr_t'(randomBits(12));
    endcase
  endfunction

  function automatic logic isIllegal(input csrAdr_t adr, input privMode_t priv,
                                     input logic virt, input logic wrEn);
    logic hReg;
    logic vsReg;
    logic result;
    hReg  = adr inside {`ADR_HSTATUS, `ADR_HEDELEG, `ADR_HIDELEG, `ADR_HIP,
                        `ADR_HVIP, `ADR_HTVAL, `ADR_HTINST};
    vsReg = adr inside {`ADR_VSSTATUS, `ADR_VSTVEC, `ADR_VSSCRATCH, `ADR_VSEPC,
                        `ADR_VSCAUSE, `ADR_VSTVAL};
    result = 1'b1;
    if (hReg) begin
      result = !((priv == PRIV_M) || (priv == PRIV_S && !virt)) ||
               (wrEn && adr == `ADR_HIP);
    end else if (vsReg) begin
      result = (priv == PRIV_U);
    end
    return result;
  endfunction

  // Mode bit 1 is dropped, base is kept
  function automatic xlenWord_t tvecAfterWrite(input xlenWord_t v);
    return {v[63:2], 1'b0, v[0]};
  endfunction

  function automatic xlenWord_t statusAfterWrite(input xlenWord_t v);
    xlenWord_t e;
    e        = '0;
    e[1]     = v[1];
    e[5]     = v[5];
    e[8]     = v[8];
    e[14:13] = v[14:13];
    e[18]    = v[18];
    e[19]    = v[19];
    e[33:32] = `UXL_VALUE;
    // SD summarizes a dirty FPU
    e[63]    = (v[14:13] == 2'b11);
    return e;
  endfunction

  task automatic initInputs();
    csrWrite    <= 1'b0;
    csrAdr      <= '0;
    csrWriteVal <= '0;
    privMode    <= PRIV_M;
    virtMode    <= 1'b0;
    mipBits     <= '0;
    hsTrap      <= 1'b0;
    vsTrap      <= 1'b0;
    hsReturn    <= 1'b0;
    vsReturn    <= 1'b0;
    nextEpc     <= '0;
    nextCause   <= '0;
    nextTval    <= '0;
    nextHtval   <= '0;
    nextHtinst  <= '0;
  endtask

  task automatic setMode(input privMode_t priv, input logic virt);
    @(posedge clk);
    privMode <= priv;
    virtMode <= virt;
  endtask

  task automatic readCsr(input csrAdr_t adr, input xlenWord_t expected);
    @(posedge clk);
    csrWrite <= 1'b0;
    csrAdr   <= adr;
    @(negedge clk);
    checkBit($sformatf("illegalAccess @%h", adr), 1'b0, illegalAccess);
    checkWord($sformatf("csrReadVal @%h", adr), expected, csrReadVal);
  endtask

  task automatic writeCsr(input csrAdr_t adr, input xlenWord_t value, input logic expIllegal);
    @(posedge clk);
    csrWrite    <= 1'b1;
    csrAdr      <= adr;
    csrWriteVal <= value;
    @(negedge clk);
    checkBit($sformatf("illegalAccess @%h", adr), expIllegal, illegalAccess);
    if (expIllegal) begin
      checkWord($sformatf("csrReadVal @%h", adr), '0, csrReadVal);
    end
    @(posedge clk);
    csrWrite <= 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic resetValues();
    irqBits_t  hv;
    irqBits_t  mip;
    csrAdr_t   adr;
    xlenWord_t expected;
    setMode(PRIV_M, 1'b0);
    for (int k = 0; k < 13; k++) begin
      adr = pickAddress(4'(k));
      // Stored state is zero, UXL in VSSTATUS is a constant
      expected = (adr == `ADR_VSSTATUS) ? {30'b0, `UXL_VALUE, 32'b0} : '0;
      readCsr(adr, expected);
    end
    checkBit("hstatusSpv", 1'b0, hstatusSpv);
    checkWord("hedeleg", '0, hedeleg);
    checkIrq("hideleg", '0, hideleg);
    checkWord("vstvec", '0, vstvec);
    checkWord("vsepc", '0, vsepc);
    // HIP merges the virtual pending bits with the machine ones
    hv = irqBits_t'(randomBits(12));
    writeCsr(`ADR_HVIP, {52'b0, hv}, 1'b0);
    for (int i = 0; i < 4; i++) begin
      mip = irqBits_t'(randomBits(12));
      @(posedge clk);
      mipBits <= mip;
      csrAdr  <= `ADR_HIP;
      @(negedge clk);
      checkWord("csrReadVal HIP", {52'b0, hv | mip}, csrReadVal);
    end
    @(posedge clk);
    mipBits <= '0;
  endtask

  task automatic writeMasking();
    xlenWord_t v;
    xlenWord_t s;
    setMode(PRIV_M, 1'b0);
    for (int i = 0; i < 6; i++) begin
      v    = randomBits(64);
      v[0] = i[0];
      writeCsr(`ADR_HEDELEG, v, 1'b0);
      readCsr(`ADR_HEDELEG, {48'b0, v[15:0]});
      checkWord("hedeleg", {48'b0, v[15:0]}, hedeleg);
      writeCsr(`ADR_HIDELEG, v, 1'b0);
      readCsr(`ADR_HIDELEG, {52'b0, v[11:0]});
      checkIrq("hideleg", v[11:0], hideleg);
      writeCsr(`ADR_VSTVEC, v, 1'b0);
      readCsr(`ADR_VSTVEC, tvecAfterWrite(v));
      checkWord("vstvec", tvecAfterWrite(v), vstvec);
      s = randomBits(64);
      if (i[0]) begin
        s[14:13] = 2'b11;
      end
      writeCsr(`ADR_VSSTATUS, s, 1'b0);
      readCsr(`ADR_VSSTATUS, statusAfterWrite(s));
    end
  endtask

  task automatic accessLegality();
    csrAdr_t   adr;
    privMode_t priv;
    logic      virt;
    logic      wrEn;
    logic      expIllegal;
    xlenWord_t keep;
    for (int i = 0; i < 48; i++) begin
      adr = pickAddress(4'(randomBits(4)));
      case (2'(randomBits(2)))
        2'd0:    priv = PRIV_U;
        2'd1:    priv = PRIV_S;
        default: priv = PRIV_M;
      endcase
      virt       = 1'(randomBits(1));
      wrEn       = 1'(randomBits(1));
      expIllegal = isIllegal(adr, priv, virt, wrEn);
      @(posedge clk);
      privMode    <= priv;
      virtMode    <= virt;
      csrWrite    <= wrEn;
      csrAdr      <= adr;
      csrWriteVal <= randomBits(64);
      @(negedge clk);
      checkBit($sformatf("illegalAccess @%h", adr), expIllegal, illegalAccess);
      if (expIllegal) begin
        checkWord($sformatf("csrReadVal @%h", adr), '0, csrReadVal);
      end
    end
    @(posedge clk);
    csrWrite <= 1'b0;
    // Blocked writes must leave the target untouched
    keep = randomBits(64);
    setMode(PRIV_M, 1'b0);
    writeCsr(`ADR_VSSCRATCH, keep, 1'b0);
    setMode(PRIV_U, 1'b1);
    writeCsr(`ADR_VSSCRATCH, ~keep, 1'b1);
    setMode(PRIV_M, 1'b0);
    readCsr(`ADR_VSSCRATCH, keep);
    writeCsr(`ADR_HTVAL, keep, 1'b0);
    setMode(PRIV_S, 1'b1);
    writeCsr(`ADR_HTVAL, ~keep, 1'b1);
    setMode(PRIV_M, 1'b0);
    readCsr(`ADR_HTVAL, keep);
    writeCsr(`ADR_HIP, keep, 1'b1);
  endtask

  task automatic hsTrapReturn();
    xlenWord_t tval;
    xlenWord_t tinst;
    tval  = randomBits(64);
    tinst = randomBits(64);
    setMode(PRIV_M, 1'b1);
    // Start from SPV clear so the trap has to set it
    writeCsr(`ADR_HSTATUS, '0, 1'b0);
    @(negedge clk);
    checkBit("hstatusSpv", 1'b0, hstatusSpv);
    // The trap must win over the CSR write to HTVAL in the same cycle
    @(posedge clk);
    hsTrap      <= 1'b1;
    nextHtval   <= tval;
    nextHtinst  <= tinst;
    csrWrite    <= 1'b1;
    csrAdr      <= `ADR_HTVAL;
    csrWriteVal <= randomBits(64);
    @(posedge clk);
    hsTrap   <= 1'b0;
    csrWrite <= 1'b0;
    @(negedge clk);
    checkBit("hstatusSpv", 1'b1, hstatusSpv);
    readCsr(`ADR_HTVAL, tval);
    readCsr(`ADR_HTINST, tinst);
    @(posedge clk);
    hsReturn <= 1'b1;
    @(posedge clk);
    hsReturn <= 1'b0;
    @(negedge clk);
    checkBit("hstatusSpv", 1'b0, hstatusSpv);
  endtask

  task automatic vsTrapReturn();
    xlenWord_t  epc;
    xlenWord_t  tval;
    logic [3:0] code;
    epc  = randomBits(64);
    tval = randomBits(64);
    code = 4'(randomBits(4));
    setMode(PRIV_M, 1'b0);
    // SIE set, SPIE clear
    writeCsr(`ADR_VSSTATUS, 64'h2, 1'b0);
    setMode(PRIV_S, 1'b1);
    @(posedge clk);
    vsTrap    <= 1'b1;
    nextEpc   <= epc;
    nextCause <= {1'b1, code};
    nextTval  <= tval;
    @(posedge clk);
    vsTrap <= 1'b0;
    @(negedge clk);
    checkWord("vsepc", epc, vsepc);
    // SPP from S mode, SPIE from old SIE, SIE clear
    readCsr(`ADR_VSSTATUS, statusAfterWrite(64'h120));
    readCsr(`ADR_VSEPC, epc);
    readCsr(`ADR_VSCAUSE, {1'b1, 59'b0, code});
    readCsr(`ADR_VSTVAL, tval);
    @(posedge clk);
    vsReturn <= 1'b1;
    @(posedge clk);
    vsReturn <= 1'b0;
    readCsr(`ADR_VSSTATUS, statusAfterWrite(64'h22));
    // SPP set with SPIE and SIE clear, so the return must raise SPIE
    writeCsr(`ADR_VSSTATUS, 64'h100, 1'b0);
    @(posedge clk);
    vsReturn <= 1'b1;
    @(posedge clk);
    vsReturn <= 1'b0;
    readCsr(`ADR_VSSTATUS, statusAfterWrite(64'h20));
  endtask

  //////////////////////////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount == CycleLimit) begin
      $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
      abortRun();
    end
  end

  initial begin
    initInputs();
    wait (reset == 1'b0);
    resetValues();
    writeMasking();
    accessLegality();
    hsTrapReturn();
    vsTrapReturn();
    $display("No errors");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
hcsr_pkg.sv
hcsr_if.sv
hcsrAccessCtrl.sv
hsRegBank.sv
vsRegBank.sv
hcsrTop.sv
tbClockGen.sv
tbHcsr.sv

//--- run.sh
#!/bin/bash
# Build and run the hypervisor CSR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tbHcsr -f sources.f -o simHcsr
./obj_dir/simHcsr > sim.log 2>&1 || true
cat sim.log

if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi
echo "Simulation passed"
